/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = sram_subsys_tb
FILELIST = filelist.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* common/sram_cfg.svh */
`ifndef SRAM_CFG_SVH
`define SRAM_CFG_SVH

// chip address width
`define SRAM_ADDR_WIDTH 8

// chip data width
`define SRAM_DATA_WIDTH 16

// caller tag, passed through untouched
`define SRAM_META_WIDTH 4

// four response slots
`define RESP_DEPTH_LOG2 2

`endif

/* common/sram_pkg.sv */
`include "sram_cfg.svh"

package sram_pkg;

  // command from the caller
  typedef struct packed {
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
    logic [`SRAM_META_WIDTH-1:0] meta;
    logic                        last;
    logic                        wr_en;
    logic [`SRAM_DATA_WIDTH-1:0] wr_data;
  } sram_cmd_t;

  // response back to the caller, also used as the pending tag
  typedef struct packed {
    logic [`SRAM_META_WIDTH-1:0] meta;
    logic                        last;
    logic [`SRAM_DATA_WIDTH-1:0] data;
  } sram_resp_t;

  // one chip access, controller to pad
  typedef struct packed {
    logic                        valid;
    logic                        wr_en;
    logic [`SRAM_ADDR_WIDTH-1:0] addr;
    logic [`SRAM_DATA_WIDTH-1:0] wr_data;
  } pad_req_t;

  // access completion, pad to response queue
  typedef struct packed {
    logic                        valid;
    logic [`SRAM_DATA_WIDTH-1:0] rd_data;
  } pad_done_t;

  // access state machine
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } ctrl_state_t;

endpackage

/* filelist.f */
+incdir+common
common/sram_pkg.sv
sram_io/sram_access_ctrl.sv
sram_io/sram_pad.sv
logic/resp_fifo.sv
logic/sram_subsys_top.sv
testbench/sram_chip_model.sv
testbench/sram_subsys_sva.sv
testbench/sram_subsys_tb.sv

/* logic/resp_fifo.sv */
`timescale 1ns/1ps

`include "sram_cfg.svh"

module resp_fifo (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  tag_push,
  input  sram_pkg::sram_resp_t  tag,
  input  sram_pkg::pad_done_t   pad_done,

  output logic                  resp_valid,
  output sram_pkg::sram_resp_t  resp,
  input  logic                  resp_ready,
  output logic                  resp_pop
);

  localparam int DEPTH = 1 << `RESP_DEPTH_LOG2;

  // one ring: push_ptr..done_ptr are pending tags, done_ptr..head_ptr are complete
  sram_pkg::sram_resp_t         entries [DEPTH];
  logic [DEPTH-1:0]             cplt;

  logic [`RESP_DEPTH_LOG2-1:0]  push_ptr;
  logic [`RESP_DEPTH_LOG2-1:0]  done_ptr;
  logic [`RESP_DEPTH_LOG2-1:0]  head_ptr;

  sram_pkg::sram_resp_t         merged;
  logic                         out_free;
  logic                         take_head;
  logic                         bypass;

  assign merged = '{
    meta: entries[done_ptr].meta,
    last: entries[done_ptr].last,
    data: pad_done.rd_data
  };

  assign out_free  = !resp_valid || resp_ready;
  assign take_head = out_free && cplt[head_ptr];
  // nothing completed is waiting, so the fresh result goes straight out
  assign bypass    = out_free && !cplt[head_ptr] && pad_done.valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cplt     <= '0;
      push_ptr <= '0;
      done_ptr <= '0;
      head_ptr <= '0;
    end else begin
      if (tag_push) begin
        push_ptr <= push_ptr + 1'b1;
      end
      if (pad_done.valid) begin
        done_ptr <= done_ptr + 1'b1;
        if (!bypass) begin
          cplt[done_ptr] <= 1'b1;
        end
      end
      if (take_head) begin
        cplt[head_ptr] <= 1'b0;
      end
      if (take_head || bypass) begin
        head_ptr <= head_ptr + 1'b1;
      end
    end
  end

  // tag written at push, data filled in on done
  always_ff @(posedge clk) begin
    if (tag_push) begin
      entries[push_ptr] <= tag;
    end
    if (pad_done.valid && !bypass) begin
      entries[done_ptr].data <= pad_done.rd_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (out_free) begin
      resp_valid <= take_head || bypass;
    end
  end

  always_ff @(posedge clk) begin
    if (take_head) begin
      resp <= entries[head_ptr];
    end else if (bypass) begin
      resp <= merged;
    end
  end

  assign resp_pop = resp_valid && resp_ready;

endmodule

/* logic/sram_subsys_top.sv */
`timescale 1ns/1ps

`include "sram_cfg.svh"

module sram_subsys_top (
  input  logic                         clk,
  input  logic                         rst_n,

  // command port
  input  logic                         cmd_valid,
  input  sram_pkg::sram_cmd_t          cmd,
  output logic                         cmd_ready,

  // response port
  output logic                         resp_valid,
  output sram_pkg::sram_resp_t         resp,
  input  logic                         resp_ready,

  // chip pins
  output logic [`SRAM_ADDR_WIDTH-1:0]  sram_addr,
  inout  wire  [`SRAM_DATA_WIDTH-1:0]  sram_data,
  output logic                         sram_we_n,
  output logic                         sram_oe_n,
  output logic                         sram_ce_n
);

  sram_pkg::pad_req_t    pad_req;
  sram_pkg::pad_done_t   pad_done;
  sram_pkg::sram_resp_t  tag;
  logic                  tag_push;
  logic                  resp_pop;

  sram_access_ctrl sram_access_ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .pad_req   (pad_req),
    .tag_push  (tag_push),
    .tag       (tag),
    .resp_pop  (resp_pop)
  );

  sram_pad sram_pad_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pad_req   (pad_req),
    .pad_done  (pad_done),
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

  // pairs each done with its tag, in accept order
  resp_fifo resp_fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .tag_push   (tag_push),
    .tag        (tag),
    .pad_done   (pad_done),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_ready (resp_ready),
    .resp_pop   (resp_pop)
  );

endmodule

/* sram_io/sram_access_ctrl.sv */
`timescale 1ns/1ps

`include "sram_cfg.svh"

module sram_access_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  cmd_valid,
  input  sram_pkg::sram_cmd_t   cmd,
  output logic                  cmd_ready,

  output sram_pkg::pad_req_t    pad_req,

  output logic                  tag_push,
  output sram_pkg::sram_resp_t  tag,
  input  logic                  resp_pop
);

  // slot count needs one extra bit to hold the full value
  localparam int CNT_W = `RESP_DEPTH_LOG2 + 1;
  localparam logic [CNT_W-1:0] SLOTS = CNT_W'(1 << `RESP_DEPTH_LOG2);

  sram_pkg::ctrl_state_t        state;
  sram_pkg::ctrl_state_t        state_next;

  logic                         accept;
  logic [CNT_W-1:0]             reserved;
  logic [CNT_W-1:0]             reserved_next;

  logic                         req_valid;
  logic                         req_wr_en;
  logic [`SRAM_ADDR_WIDTH-1:0]  req_addr;
  logic [`SRAM_DATA_WIDTH-1:0]  req_wr_data;

  assign accept = cmd_valid && cmd_ready;

  // one access at a time, always back to idle afterwards
  always_comb begin
    state_next = state;

    case (state)
      sram_pkg::ST_IDLE: begin
        if (accept) begin
          if (cmd.wr_en) begin
            state_next = sram_pkg::ST_WRITE;
          end else begin
            state_next = sram_pkg::ST_READ;
          end
        end
      end

      sram_pkg::ST_READ: begin
        state_next = sram_pkg::ST_IDLE;
      end

      sram_pkg::ST_WRITE: begin
        state_next = sram_pkg::ST_IDLE;
      end

      default: begin
        state_next = sram_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= sram_pkg::ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // slot reserved at accept, released when the caller takes the response
  always_comb begin
    case ({accept, resp_pop})
      2'b10:   reserved_next = reserved + 1'b1;
      2'b01:   reserved_next = reserved - 1'b1;
      default: reserved_next = reserved;
    endcase
  end

  // ready is registered, so it drops for the cycle after each accept
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reserved  <= '0;
      cmd_ready <= 1'b0;
    end else begin
      reserved  <= reserved_next;
      cmd_ready <= (state_next == sram_pkg::ST_IDLE) && (reserved_next != SLOTS);
    end
  end

  // request strobe, one cycle per accepted command
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_wr_en   <= (state_next == sram_pkg::ST_WRITE);
      req_addr    <= cmd.addr;
      req_wr_data <= cmd.wr_data;
    end
  end

  assign pad_req = '{
    valid:   req_valid,
    wr_en:   req_wr_en,
    addr:    req_addr,
    wr_data: req_wr_data
  };

  // tag goes into the response queue in accept order
  assign tag_push = accept;
  assign tag      = '{meta: cmd.meta, last: cmd.last, data: '0};

endmodule

/* sram_io/sram_pad.sv */
`timescale 1ns/1ps

`include "sram_cfg.svh"

module sram_pad (
  input  logic                         clk,
  input  logic                         rst_n,

  input  sram_pkg::pad_req_t           pad_req,
  output sram_pkg::pad_done_t          pad_done,

  output logic [`SRAM_ADDR_WIDTH-1:0]  sram_addr,
  inout  wire  [`SRAM_DATA_WIDTH-1:0]  sram_data,
  output logic                         sram_we_n,
  output logic                         sram_oe_n,
  output logic                         sram_ce_n
);

  logic [`SRAM_DATA_WIDTH-1:0] wr_data;
  logic [`SRAM_DATA_WIDTH-1:0] rd_data;
  logic                        done_valid;

  // strobes straight off flops, low for exactly one cycle per access
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sram_ce_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_we_n  <= 1'b1;
      done_valid <= 1'b0;
    end else begin
      sram_ce_n  <= 1'b0;
      sram_oe_n  <= !(pad_req.valid && !pad_req.wr_en);
      sram_we_n  <= !(pad_req.valid && pad_req.wr_en);
      // done follows the strobe cycle
      done_valid <= !sram_oe_n || !sram_we_n;
    end
  end

  // address and write data held until the next request
  always_ff @(posedge clk) begin
    if (pad_req.valid) begin
      sram_addr <= pad_req.addr;
      wr_data   <= pad_req.wr_data;
    end
  end

  // sample at the end of the read cycle
  always_ff @(posedge clk) begin
    if (!sram_oe_n) begin
      rd_data <= sram_data;
    end
  end

  // drive the bus only while we_n is low
  assign sram_data = !sram_we_n ? wr_data : 'z;

  assign pad_done = '{valid: done_valid, rd_data: rd_data};

endmodule

/* testbench/sram_chip_model.sv */
`timescale 1ns/1ps

`include "sram_cfg.svh"

module sram_chip_model (
  input  logic [`SRAM_ADDR_WIDTH-1:0]  sram_addr,
  inout  wire  [`SRAM_DATA_WIDTH-1:0]  sram_data,
  input  logic                         sram_we_n,
  input  logic                         sram_oe_n,
  input  logic                         sram_ce_n
);

  localparam int DW    = `SRAM_DATA_WIDTH;
  localparam int WORDS = 1 << `SRAM_ADDR_WIDTH;

  logic [DW-1:0] mem [WORDS];

  // power-up contents depend on every address bit
  initial begin
    for (int a = 0; a < WORDS; a++) begin
      mem[a] = DW'(a * 257) ^ DW'(16'h5aa5);
    end
  end

  // write lands mid-pulse, once address and data have settled
  always @(negedge sram_we_n) begin
    #10;
    if (!sram_ce_n && !sram_we_n) begin
      mem[sram_addr] = sram_data;
    end
  end

  // output enable drives the bus, asynchronous read
  assign sram_data = (!sram_ce_n && !sram_oe_n && sram_we_n) ? mem[sram_addr] : 'z;

endmodule

/* testbench/sram_subsys_sva.sv */
`timescale 1ns/1ps

module sram_subsys_sva (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  cmd_valid,
  input sram_pkg::sram_cmd_t   cmd,
  input logic                  cmd_ready,
  input logic                  resp_valid,
  input sram_pkg::sram_resp_t  resp,
  input logic                  resp_ready,
  input logic                  sram_we_n,
  input logic                  sram_oe_n
);

  // a stalled response holds still
  resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
    else $error("resp changed while resp_ready was low");

  strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    sram_we_n || sram_oe_n)
    else $error("sram_we_n and sram_oe_n low together");

  we_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    !sram_we_n |=> sram_we_n)
    else $error("sram_we_n low for more than one cycle");

  // strobe two edges after the accepting edge
  write_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && cmd_ready && cmd.wr_en |-> ##2 !sram_we_n)
    else $error("accepted write gave no sram_we_n pulse");

  read_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && cmd_ready && !cmd.wr_en |-> ##2 (!sram_oe_n && sram_we_n))
    else $error("accepted read gave a wrong strobe pattern");

  we_only_for_write: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(sram_we_n) |-> $past(cmd_valid && cmd_ready && cmd.wr_en, 2))
    else $error("sram_we_n pulse without an accepted write");

endmodule

bind sram_subsys_top sram_subsys_sva sva0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .cmd_valid  (cmd_valid),
  .cmd        (cmd),
  .cmd_ready  (cmd_ready),
  .resp_valid (resp_valid),
  .resp       (resp),
  .resp_ready (resp_ready),
  .sram_we_n  (sram_we_n),
  .sram_oe_n  (sram_oe_n)
);

/* testbench/sram_subsys_tb.sv */
`timescale 1ns/1ps

`include "sram_cfg.svh"

module sram_subsys_tb;

  localparam int DW              = `SRAM_DATA_WIDTH;
  localparam int SLOTS           = 1 << `RESP_DEPTH_LOG2;
  localparam int NUM_STEPS       = 14;
  localparam int WATCHDOG_CYCLES = NUM_STEPS * 20;

  typedef struct packed {
    logic                         wr_en;
    logic [`SRAM_ADDR_WIDTH-1:0]  addr;
    logic [`SRAM_META_WIDTH-1:0]  meta;
    logic                         last;
    logic [7:0]                   hold;
  } step_t;

  typedef struct packed {
    logic                  wr_en;
    logic [7:0]            step;
    sram_pkg::sram_resp_t  resp;
  } expect_t;

  typedef struct packed {
    logic cmd_ready;
    logic resp_valid;
    logic sram_we_n;
    logic sram_oe_n;
  } idle_pins_t;

  // wr_en, addr, meta, last, cycles with resp_ready low
  localparam step_t STEPS [NUM_STEPS] = '{
    '{1'b1, 8'h10, 4'h1, 1'b0, 8'd0},
    '{1'b0, 8'h10, 4'h2, 1'b1, 8'd0},
    '{1'b0, 8'h20, 4'h3, 1'b0, 8'd0},
    '{1'b1, 8'h20, 4'h4, 1'b0, 8'd1},
    '{1'b0, 8'h20, 4'h5, 1'b1, 8'd0},
    '{1'b1, 8'h30, 4'h6, 1'b0, 8'd0},
    // held long enough for four commands to pile up
    '{1'b0, 8'h30, 4'h7, 1'b0, 8'd15},
    '{1'b1, 8'h40, 4'h8, 1'b0, 8'd0},
    '{1'b0, 8'h41, 4'h9, 1'b1, 8'd0},
    '{1'b0, 8'h40, 4'ha, 1'b0, 8'd0},
    '{1'b1, 8'hff, 4'hb, 1'b1, 8'd0},
    '{1'b0, 8'h10, 4'hc, 1'b0, 8'd2},
    '{1'b0, 8'hff, 4'hd, 1'b1, 8'd0},
    '{1'b0, 8'h00, 4'he, 1'b1, 8'd0}
  };

  logic                         clk;
  logic                         rst_n;
  logic                         cmd_valid;
  sram_pkg::sram_cmd_t          cmd;
  logic                         cmd_ready;
  logic                         resp_valid;
  sram_pkg::sram_resp_t         resp;
  logic                         resp_ready;
  logic [`SRAM_ADDR_WIDTH-1:0]  sram_addr;
  wire  [`SRAM_DATA_WIDTH-1:0]  sram_data;
  logic                         sram_we_n;
  logic                         sram_oe_n;
  logic                         sram_ce_n;

  logic [DW-1:0]  ref_mem [1 << `SRAM_ADDR_WIDTH];
  expect_t        expected [$];
  int             accepted;
  int             taken;
  int             tests;
  int             errors;
  bit             full_stall_seen;

  sram_subsys_top dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .resp_valid (resp_valid),
    .resp       (resp),
    .resp_ready (resp_ready),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

  sram_chip_model chip0 (
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

  always #50 clk = ~clk;

  // chip contents at power-up
  function automatic logic [DW-1:0] power_up_word(input int a);
    return DW'(a * 257) ^ DW'(16'h5aa5);
  endfunction

  task automatic check_resp(input int idx, input sram_pkg::sram_resp_t got,
                            input sram_pkg::sram_resp_t exp, input logic wr);
    logic ok;
    // write responses carry no data
    ok = (got.meta === exp.meta) && (got.last === exp.last) && (wr || got.data === exp.data);
    tests++;
    if (!ok) begin
      errors++;
      $display("Mismatch at %0t: step %0d got meta %h last %b data %h", $time, idx,
               got.meta, got.last, got.data);
      $display("  expected meta %h last %b data %h", exp.meta, exp.last, exp.data);
    end
    $display("step %0d %s: %s", idx, wr ? "write" : "read", ok ? "ok" : "failed");
  endtask

  task automatic check_idle_pins(input idle_pins_t got, input idle_pins_t exp);
    tests++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: idle pins %b, expected %b", $time, got, exp);
    end
    $display("reset idle state: %s", (got === exp) ? "ok" : "failed");
  endtask

  task automatic record_accept();
    expect_t e;
    if (accepted - taken >= SLOTS) begin
      errors++;
      $display("command accepted at %0t while all response slots were reserved", $time);
    end
    e.wr_en = cmd.wr_en;
    e.step  = 8'(accepted);
    e.resp  = '{meta: cmd.meta, last: cmd.last, data: ref_mem[cmd.addr]};
    if (cmd.wr_en) begin
      ref_mem[cmd.addr] = cmd.wr_data;
    end
    expected.push_back(e);
    accepted++;
  endtask

  task automatic take_response();
    expect_t e;
    if (expected.size() == 0) begin
      errors++;
      $display("response at %0t with no command outstanding", $time);
    end else begin
      e = expected.pop_front();
      check_resp(int'(e.step), resp, e.resp, e.wr_en);
    end
    taken++;
  endtask

  // handshakes sampled mid-cycle and completed at the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (cmd_valid && !cmd_ready && (accepted - taken == SLOTS)) begin
        full_stall_seen = 1'b1;
      end
      if (cmd_valid && cmd_ready) begin
        record_accept();
      end
      if (resp_valid && resp_ready) begin
        take_response();
      end
    end
  end

  task automatic drive_commands();
    for (int i = 0; i < NUM_STEPS; i++) begin
      cmd = '{addr: STEPS[i].addr, meta: STEPS[i].meta, last: STEPS[i].last,
              wr_en: STEPS[i].wr_en, wr_data: DW'($urandom)};
      cmd_valid = 1'b1;
      @(negedge clk);
      while (!cmd_ready) @(negedge clk);
      @(posedge clk);
      #1;
    end
    cmd_valid = 1'b0;
  endtask

  task automatic drive_resp_ready();
    for (int i = 0; i < NUM_STEPS; i++) begin
      if (STEPS[i].hold != 8'd0) begin
        resp_ready = 1'b0;
      end
      @(negedge clk);
      while (!resp_valid) @(negedge clk);
      if (STEPS[i].hold != 8'd0) begin
        repeat (STEPS[i].hold) @(posedge clk);
        #1;
        resp_ready = 1'b1;
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    void'($urandom(81));
    clk             = 1'b0;
    rst_n           = 1'b0;
    cmd_valid       = 1'b0;
    cmd             = '0;
    resp_ready      = 1'b0;
    accepted        = 0;
    taken           = 0;
    tests           = 0;
    errors          = 0;
    full_stall_seen = 1'b0;
    for (int a = 0; a < (1 << `SRAM_ADDR_WIDTH); a++) begin
      ref_mem[a] = power_up_word(a);
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_idle_pins('{cmd_ready, resp_valid, sram_we_n, sram_oe_n}, '{1'b0, 1'b0, 1'b1, 1'b1});
    resp_ready = 1'b1;
    @(posedge clk);
    #1;
    tests++;
    if (sram_ce_n !== 1'b0) begin
      errors++;
      $display("Mismatch at %0t: sram_ce_n %b one cycle after reset, expected 0",
               $time, sram_ce_n);
    end
    $display("chip enable after reset: %s", (sram_ce_n === 1'b0) ? "ok" : "failed");
    fork
      drive_commands();
      drive_resp_ready();
    join
    repeat (4) @(posedge clk);
    if (!full_stall_seen) begin
      errors++;
      $display("cmd_ready never dropped with four responses outstanding");
    end
    $display("tests: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // run length bound from the table size
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles, %0d responses outstanding",
             WATCHDOG_CYCLES, expected.size());
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
